/* verilog/vic_pkg.sv */
`default_nettype none

package vic_pkg;

   // chip model, bit value follows the ntsc/pal strap of the board
   typedef enum logic {
      CHIP_NTSC = 1'b0,   // 6567 timing
      CHIP_PAL  = 1'b1    // 6569 timing
   } chip_t;

   localparam int X_W = 10;   // dot counter width
   localparam int Y_W = 9;    // line counter width

   // per chip tables are indexed by chip_t, ntsc entry first
   localparam logic [X_W-1:0] H_TOTAL [2] = '{X_W'(520), X_W'(504)};   // dots per line
   localparam logic [Y_W-1:0] V_TOTAL [2] = '{Y_W'(263), Y_W'(312)};   // lines per frame

   // visible area, shared width
   localparam logic [X_W-1:0] H_ACTIVE = X_W'(400);
   localparam logic [Y_W-1:0] V_ACTIVE [2] = '{Y_W'(235), Y_W'(284)};

   // display window, border surrounds it
   localparam logic [X_W-1:0] WIN_X0 = X_W'(40);
   localparam logic [X_W-1:0] WIN_X1 = X_W'(360);    // first column past the window
   localparam logic [Y_W-1:0] WIN_Y0 [2] = '{Y_W'(16), Y_W'(30)};
   localparam logic [Y_W-1:0] WIN_Y1 [2] = '{Y_W'(216), Y_W'(254)};

   // horizontal sync pulse, both chips
   localparam logic [X_W-1:0] HS_START = X_W'(410);
   localparam logic [X_W-1:0] HS_END   = X_W'(450);

   // vertical sync sits a few lines below the visible area
   localparam logic [Y_W-1:0] VS_START [2] = '{
      V_ACTIVE[CHIP_NTSC] + Y_W'(4),
      V_ACTIVE[CHIP_PAL]  + Y_W'(4)
   };
   localparam logic [Y_W-1:0] VS_END [2] = '{
      V_ACTIVE[CHIP_NTSC] + Y_W'(7),   // three lines of vsync
      V_ACTIVE[CHIP_PAL]  + Y_W'(7)
   };

endpackage : vic_pkg

`default_nettype wire

/* verilog/video_pkg.sv */
`default_nettype none

package video_pkg;

   // the sixteen fixed colors of the chip
   typedef enum logic [3:0] {
      BLACK       = 4'd0,
      WHITE       = 4'd1,
      RED         = 4'd2,
      CYAN        = 4'd3,
      PURPLE      = 4'd4,
      GREEN       = 4'd5,
      BLUE        = 4'd6,
      YELLOW      = 4'd7,
      ORANGE      = 4'd8,
      BROWN       = 4'd9,
      PINK        = 4'd10,
      DARK_GREY   = 4'd11,
      GREY        = 4'd12,
      LIGHT_GREEN = 4'd13,
      LIGHT_BLUE  = 4'd14,
      LIGHT_GREY  = 4'd15
   } color_t;

   // 6 bit red, green, blue per entry, indexed by color_t
   localparam logic [17:0] PALETTE [16] = '{
      {6'h00, 6'h00, 6'h00},   // black
      {6'h3f, 6'h3f, 6'h3f},   // white
      {6'h2b, 6'h0a, 6'h0a},   // red
      {6'h1c, 6'h3a, 6'h3c},   // cyan
      {6'h2c, 6'h0e, 6'h2d},   // purple
      {6'h14, 6'h34, 6'h12},   // green
      {6'h0d, 6'h0c, 6'h2f},   // blue
      {6'h3b, 6'h3d, 6'h1c},   // yellow
      {6'h2d, 6'h19, 6'h07},   // orange
      {6'h1a, 6'h10, 6'h00},   // brown
      {6'h3a, 6'h1e, 6'h1e},   // pink
      {6'h13, 6'h13, 6'h13},   // dark grey
      {6'h1f, 6'h1f, 6'h1f},   // grey
      {6'h29, 6'h3f, 6'h26},   // light green
      {6'h1e, 6'h1d, 6'h3f},   // light blue
      {6'h2d, 6'h2d, 6'h2d}    // light grey
   };

   // one dot of the raster, fields valid while strobe is high
   typedef struct packed {
      logic   strobe;   // new dot this cycle
      logic   de;       // visible area
      logic   hsync;
      logic   vsync;
      color_t color;
   } pixel_t;

   // encoder side of the stream, 8 bits per channel
   typedef struct packed {
      logic       strobe;
      logic       de;
      logic       hsync;
      logic       vsync;
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
   } rgb_t;

endpackage : video_pkg

`default_nettype wire

/* verilog/raster_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module raster_gen #(
   parameter int PIXEL_DIV = 4             // clk_dot4x cycles per dot
) (
   input  logic              clk_dot4x,
   input  logic              rst_n,
   input  vic_pkg::chip_t    chip,
   input  video_pkg::color_t border_color,
   input  video_pkg::color_t bg_color,
   output video_pkg::pixel_t pix
);
   import vic_pkg::*;
   import video_pkg::*;

   localparam int DIV_W = (PIXEL_DIV > 1) ? $clog2(PIXEL_DIV) : 1;

   logic [DIV_W-1:0] div_cnt;       // phase inside the current dot
   logic             dot_en;        // a dot is issued this cycle
   logic [X_W-1:0]   x_cnt;         // raster column
   logic [Y_W-1:0]   y_cnt;         // raster line
   logic             frame_start;   // issuing dot (0,0)
   chip_t            chip_q;
   color_t           border_q;
   color_t           bg_q;
   chip_t            cfg_chip;      // config seen by this dot
   color_t           cfg_border;
   color_t           cfg_bg;
   logic [X_W-1:0]   win_dx;        // column relative to window edge
   logic             in_win;
   pixel_t           pix_next;

   // divider, phase 0 is the first cycle out of reset
   always_ff @(posedge clk_dot4x or negedge rst_n) begin
      if (!rst_n) begin
         div_cnt <= '0;
      end else if (div_cnt == DIV_W'(PIXEL_DIV - 1)) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   assign dot_en      = (div_cnt == '0);
   assign frame_start = dot_en && (x_cnt == '0) && (y_cnt == '0);

   // the first dot of a frame already uses the new config
   assign cfg_chip   = frame_start ? chip : chip_q;
   assign cfg_border = frame_start ? border_color : border_q;
   assign cfg_bg     = frame_start ? bg_color : bg_q;

   always_ff @(posedge clk_dot4x or negedge rst_n) begin
      if (!rst_n) begin
         chip_q <= CHIP_NTSC;
      end else if (frame_start) begin
         chip_q <= chip;   // geometry fixed for the frame
      end
   end

   always_ff @(posedge clk_dot4x) begin
      if (frame_start) begin
         border_q <= border_color;
         bg_q     <= bg_color;
      end
   end

   // raster walk, wraps on the frame's own totals
   always_ff @(posedge clk_dot4x or negedge rst_n) begin
      if (!rst_n) begin
         x_cnt <= '0;
         y_cnt <= '0;
      end else if (dot_en) begin
         if (x_cnt == H_TOTAL[cfg_chip] - 1'b1) begin
            x_cnt <= '0;
            if (y_cnt == V_TOTAL[cfg_chip] - 1'b1) begin
               y_cnt <= '0;   // next frame
            end else begin
               y_cnt <= y_cnt + 1'b1;
            end
         end else begin
            x_cnt <= x_cnt + 1'b1;
         end
      end
   end

   // region decode of the current position
   always_comb begin
      win_dx = x_cnt - WIN_X0;
      in_win = (x_cnt >= WIN_X0) && (x_cnt < WIN_X1) &&
               (y_cnt >= WIN_Y0[cfg_chip]) && (y_cnt < WIN_Y1[cfg_chip]);
      pix_next.strobe = 1'b1;
      pix_next.de     = (x_cnt < H_ACTIVE) && (y_cnt < V_ACTIVE[cfg_chip]);
      pix_next.hsync  = (x_cnt >= HS_START) && (x_cnt < HS_END);
      pix_next.vsync  = (y_cnt >= VS_START[cfg_chip]) && (y_cnt < VS_END[cfg_chip]);
      if (!pix_next.de) begin
         pix_next.color = BLACK;   // blanking
      end else if (in_win) begin
         // bars 8 dots wide, stepping through the colors from bg
         pix_next.color = color_t'(4'(cfg_bg + {1'b0, win_dx[5:3]}));
      end else begin
         pix_next.color = cfg_border;
      end
   end

   always_ff @(posedge clk_dot4x or negedge rst_n) begin
      if (!rst_n) begin
         pix <= '0;
      end else if (dot_en) begin
         pix <= pix_next;
      end else begin
         pix.strobe <= 1'b0;   // other fields hold until the next dot
      end
   end

endmodule : raster_gen

`default_nettype wire

/* verilog/pixel_delay.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_delay #(
   parameter int DELAY = 3                 // pipeline stages, 1 or more
) (
   input  logic              clk_dot4x,
   input  logic              rst_n,
   input  video_pkg::pixel_t pix_in,
   output video_pkg::pixel_t pix_out
);
   import video_pkg::*;

   pixel_t line_q [DELAY];   // stage 0 takes the input

   // cleared so no stale strobe comes out while the line fills
   always_ff @(posedge clk_dot4x or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DELAY; i++) begin
            line_q[i] <= '0;
         end
      end else begin
         line_q[0] <= pix_in;
         for (int i = 1; i < DELAY; i++) begin
            line_q[i] <= line_q[i-1];   // shift one stage per cycle
         end
      end
   end

   assign pix_out = line_q[DELAY-1];   // input from DELAY cycles ago

endmodule : pixel_delay

`default_nettype wire

/* verilog/palette_out.sv */
`timescale 1ns/1ps
`default_nettype none

module palette_out (
   input  logic              clk_dot4x,
   input  logic              rst_n,
   input  video_pkg::pixel_t pix,
   output video_pkg::rgb_t   video
);
   import video_pkg::*;

   logic [17:0] entry;    // 6 bit r, g, b
   logic [7:0]  red8;
   logic [7:0]  green8;
   logic [7:0]  blue8;

   // stretch 0..63 to 0..255, truncating like the dvi path on the board
   function automatic logic [7:0] scale6(input logic [5:0] c6);
      logic [15:0] prod;
      prod = 16'(c6) * 16'd255;
      return 8'(prod / 16'd63);
   endfunction

   assign entry  = PALETTE[pix.color];
   assign red8   = scale6(entry[17:12]);
   assign green8 = scale6(entry[11:6]);
   assign blue8  = scale6(entry[5:0]);

   // one register stage, sync bits travel with their color
   always_ff @(posedge clk_dot4x or negedge rst_n) begin
      if (!rst_n) begin
         video <= '0;
      end else begin
         video.strobe <= pix.strobe;
         video.de     <= pix.de;
         video.hsync  <= pix.hsync;
         video.vsync  <= pix.vsync;
         video.red    <= pix.de ? red8 : 8'h00;     // black outside the visible area
         video.green  <= pix.de ? green8 : 8'h00;
         video.blue   <= pix.de ? blue8 : 8'h00;
      end
   end

endmodule : palette_out

`default_nettype wire

/* verilog/video_top.sv */
`timescale 1ns/1ps
`default_nettype none

module video_top #(
   parameter int PIXEL_DIV = 4,            // clk_dot4x cycles per dot
   parameter int DELAY     = 3             // encoder alignment stages
) (
   input  logic              clk_dot4x,
   input  logic              rst_n,
   input  vic_pkg::chip_t    chip,
   input  video_pkg::color_t border_color,
   input  video_pkg::color_t bg_color,
   output video_pkg::rgb_t   video
);
   import video_pkg::*;

   pixel_t pix_raw;   // straight from the raster
   pixel_t pix_dly;   // aligned with the encoder

   raster_gen #(.PIXEL_DIV(PIXEL_DIV)) raster_gen_inst (
      .clk_dot4x(clk_dot4x),
      .rst_n(rst_n),
      .chip(chip),
      .border_color(border_color),
      .bg_color(bg_color),
      .pix(pix_raw)
   );

   pixel_delay #(.DELAY(DELAY)) pixel_delay_inst (
      .clk_dot4x(clk_dot4x),
      .rst_n(rst_n),
      .pix_in(pix_raw),
      .pix_out(pix_dly)
   );

   // dot reaches video DELAY + 1 cycles after raster_gen
   palette_out palette_out_inst (
      .clk_dot4x(clk_dot4x),
      .rst_n(rst_n),
      .pix(pix_dly),
      .video(video)
   );

endmodule : video_top

`default_nettype wire

/* test/video_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module video_top_tb;
   import vic_pkg::*;
   import video_pkg::*;

   localparam int PIXEL_DIV  = 4;
   localparam int DELAY      = 3;
   localparam int NUM_FRAMES = 6;
   // pal has the longest frame, so it bounds every frame of the run
   localparam int FRAME_CYCLES =
      int'(H_TOTAL[CHIP_PAL]) * int'(V_TOTAL[CHIP_PAL]) * PIXEL_DIV;
   localparam int WATCHDOG_CYCLES = NUM_FRAMES * FRAME_CYCLES + 2000;   // reset and latency margin
   localparam chip_t CHIP_SEQ [NUM_FRAMES] = '{
      CHIP_PAL, CHIP_PAL, CHIP_NTSC, CHIP_NTSC, CHIP_PAL, CHIP_NTSC
   };

   logic   clk_dot4x;
   logic   rst_n;
   chip_t  chip;
   color_t border_color;
   color_t bg_color;
   rgb_t   video;

   int             seed;
   int             rnd;
   logic [X_W-1:0] mx = '0;               // model column of the next dot
   logic [Y_W-1:0] my = '0;               // model line of the next dot
   chip_t          fchip = CHIP_PAL;      // config the model holds for this frame
   color_t         fborder = BLACK;
   color_t         fbg = BLACK;
   int             frames_done = 0;
   int             cycle = 0;             // clocks since reset release
   int             last_strobe = 0;
   logic           seen_strobe = 1'b0;
   rgb_t           exp_dot;

   video_top #(.PIXEL_DIV(PIXEL_DIV), .DELAY(DELAY)) UUT (
      .clk_dot4x(clk_dot4x),
      .rst_n(rst_n),
      .chip(chip),
      .border_color(border_color),
      .bg_color(bg_color),
      .video(video)
   );

   initial begin
      clk_dot4x = 1'b0;
      forever #20 clk_dot4x = ~clk_dot4x;   // 40 ns period
   end

   // 0..63 stretched to 0..255, truncated
   function automatic logic [7:0] scale_channel(input logic [5:0] c6);
      int v;
      v = int'(c6) * 255 / 63;
      return v[7:0];
   endfunction

   // expected output for dot (x, y) of a frame with the given config
   function automatic rgb_t predict_dot(input chip_t c, input color_t border,
                                        input color_t bg, input logic [X_W-1:0] x,
                                        input logic [Y_W-1:0] y);
      rgb_t           e;
      logic [17:0]    entry;
      logic [X_W-1:0] dx;
      int             idx;
      e        = '0;
      e.strobe = 1'b1;
      e.de     = (x < H_ACTIVE) && (y < V_ACTIVE[c]);
      e.hsync  = (x >= HS_START) && (x < HS_END);
      e.vsync  = (y >= VS_START[c]) && (y < VS_END[c]);
      dx       = x - WIN_X0;
      if (!e.de) begin
         idx = 0;                                        // blanking is black
      end else if ((x >= WIN_X0) && (x < WIN_X1) && (y >= WIN_Y0[c]) && (y < WIN_Y1[c])) begin
         idx = (int'(bg) + (int'(dx) / 8) % 8) % 16;     // bars of 8 dots
      end else begin
         idx = int'(border);
      end
      entry = PALETTE[idx[3:0]];
      if (e.de) begin
         e.red   = scale_channel(entry[17:12]);
         e.green = scale_channel(entry[11:6]);
         e.blue  = scale_channel(entry[5:0]);
      end
      return e;
   endfunction

   task automatic abort_run();
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   task automatic check_sync(input rgb_t expected, input rgb_t got);
      if ({got.de, got.hsync, got.vsync} !==
          {expected.de, expected.hsync, expected.vsync}) begin
         $display("** Error video.{de,hsync,vsync} expected %h got %h at dot (%0d,%0d)",
                  {expected.de, expected.hsync, expected.vsync},
                  {got.de, got.hsync, got.vsync}, mx, my);
         abort_run();
      end
   endtask

   task automatic check_rgb(input rgb_t expected, input rgb_t got);
      if ({got.red, got.green, got.blue} !== {expected.red, expected.green, expected.blue}) begin
         $display("** Error video.{red,green,blue} expected %h got %h at dot (%0d,%0d)",
                  {expected.red, expected.green, expected.blue},
                  {got.red, got.green, got.blue}, mx, my);
         abort_run();
      end
   endtask

   // outputs settle after the rising edge, so everything is sampled on the falling one
   always @(negedge clk_dot4x) begin
      if (rst_n !== 1'b1) begin
         if (video.strobe || video.de || video.hsync || video.vsync) begin
            $display("video strobe or sync bits active while reset is held");
            abort_run();
         end
      end else begin
         cycle = cycle + 1;
         if (!video.strobe) begin
            if (!seen_strobe && (video.de || video.hsync || video.vsync)) begin
               $display("video de or sync bits active before the first dot");
               abort_run();
            end
         end else if (seen_strobe && (cycle - last_strobe != PIXEL_DIV)) begin
            $display("video strobes came %0d cycles apart instead of %0d",
                     cycle - last_strobe, PIXEL_DIV);
            abort_run();
         end else begin
            seen_strobe = 1'b1;
            last_strobe = cycle;
            if (mx == '0 && my == '0) begin
               fchip   = chip;           // inputs were set during the last vsync
               fborder = border_color;
               fbg     = bg_color;
            end
            exp_dot = predict_dot(fchip, fborder, fbg, mx, my);
            check_sync(exp_dot, video);
            check_rgb(exp_dot, video);
            // raster order, left to right then top to bottom
            if (mx == H_TOTAL[fchip] - X_W'(1)) begin
               mx = '0;
               if (my == V_TOTAL[fchip] - Y_W'(1)) begin
                  my          = '0;
                  frames_done = frames_done + 1;
               end else begin
                  my = my + Y_W'(1);
               end
            end else begin
               mx = mx + X_W'(1);
            end
         end
      end
   end

   initial begin
      seed         = 60;
      rst_n        = 1'b0;
      chip         = CHIP_SEQ[0];
      border_color = LIGHT_BLUE;
      bg_color     = BLUE;
      repeat (8) @(posedge clk_dot4x);
      #2;
      rst_n = 1'b1;
      for (int f = 0; f < NUM_FRAMES - 1; f++) begin
         // wait for the vsync lines of frame f
         while (!(frames_done == f && my >= VS_START[fchip] && my < VS_END[fchip])) begin
            @(posedge clk_dot4x);
         end
         rnd = $random(seed);
         repeat (rnd[9:0]) @(posedge clk_dot4x);   // up to 1023 cycles, still in vsync
         #2;
         chip         = CHIP_SEQ[f+1];             // takes effect at the next frame
         rnd          = $random(seed);
         border_color = color_t'(rnd[3:0]);
         bg_color     = color_t'(rnd[7:4]);
      end
      while (frames_done < NUM_FRAMES) begin
         @(posedge clk_dot4x);
      end
      $display("SIMULATION PASSED");
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_dot4x);
      $display("watchdog expired after %0d cycles before %0d frames were seen",
               WATCHDOG_CYCLES, NUM_FRAMES);
      abort_run();
   end

endmodule : video_top_tb

`default_nettype wire

/* video_top.f */
verilog/vic_pkg.sv
verilog/video_pkg.sv
verilog/raster_gen.sv
verilog/pixel_delay.sv
verilog/palette_out.sv
verilog/video_top.sv
test/video_top_tb.sv

/* Makefile */
# Verilator build and run of the video output testbench

SIM  := obj_dir/Vvideo_top_tb
SRCS := $(shell cat video_top.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): video_top.f $(SRCS)
	verilator --binary -j 0 --timescale 1ns/1ps --top-module video_top_tb -f video_top.f

# passes only if the pass message shows up in the output
run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
